// File: common/dp_ctrl_pkg.sv
`default_nettype none

package dp_ctrl_pkg;

  // ----------------------------------------
  // bus driver selects
  // ----------------------------------------

  // who drives the internal data bus this cycle
  typedef enum logic [2:0] {
    DS_EXT  = 3'd0,
    DS_REG  = 3'd1,
    DS_A    = 3'd2,
    DS_F    = 3'd3,
    DS_TEMP = 3'd4
  } data_src_t;

  // who drives the external address bus, AS_NONE leaves it released
  typedef enum logic [1:0] {
    AS_NONE = 2'd0,
    AS_MAR  = 2'd1,
    AS_PAIR = 2'd2
  } addr_src_t;

  // ----------------------------------------
  // register selects
  // ----------------------------------------

  // byte select, ordered so that a pair is always high byte then low byte
  typedef enum logic [3:0] {
    REG_B,   REG_C,   REG_D,   REG_E,   REG_H,   REG_L,
    REG_IXH, REG_IXL, REG_IYH, REG_IYL, REG_SPH, REG_SPL,
    REG_PCH, REG_PCL
  } reg8_t;

  // pair n covers bytes 2n (high) and 2n+1 (low) of reg8_t
  typedef enum logic [2:0] {
    PAIR_BC, PAIR_DE, PAIR_HL, PAIR_IX, PAIR_IY, PAIR_SP, PAIR_PC
  } reg16_t;

  // ----------------------------------------
  // ALU, flag and MAR controls
  // ----------------------------------------

  typedef enum logic [2:0] {
    ALU_PASS, ALU_INC, ALU_DEC, ALU_ADD, ALU_SUB
  } alu_op_t;

  // forced action on one flag bit
  typedef enum logic [1:0] {
    FLAG_KEEP, FLAG_CLR, FLAG_SET
  } flag_act_t;

  typedef struct packed {
    flag_act_t s;
    flag_act_t z;
    flag_act_t h;
    flag_act_t pv;
    flag_act_t n;
    flag_act_t c;
  } flag_force_t;

  typedef enum logic [1:0] {
    MAR_KEEP, MAR_HI, MAR_LO, MAR_PAIR
  } mar_ld_t;

  // all control for one cycle, presented by the sequencer
  typedef struct packed {
    data_src_t   data_src;
    addr_src_t   addr_src;
    reg8_t       reg_sel;
    reg16_t      pair_sel;
    logic        reg_ld_byte;
    logic        reg_ld_pair;
    logic        ld_a;
    logic        a_from_alu;
    logic        f_from_alu;
    alu_op_t     alu_op;
    flag_force_t flag_force;
    logic        ld_temp;
    mar_ld_t     mar_ld;
    logic        exx;
    logic        ex_af;
  } micro_op_t;

  // nothing is loaded and neither bus is driven
  localparam micro_op_t MICRO_OP_IDLE = '{
    data_src:    DS_EXT,
    addr_src:    AS_NONE,
    reg_sel:     REG_B,
    pair_sel:    PAIR_BC,
    reg_ld_byte: 1'b0,
    reg_ld_pair: 1'b0,
    ld_a:        1'b0,
    a_from_alu:  1'b0,
    f_from_alu:  1'b0,
    alu_op:      ALU_PASS,
    flag_force:  '{s: FLAG_KEEP, z: FLAG_KEEP, h: FLAG_KEEP,
                   pv: FLAG_KEEP, n: FLAG_KEEP, c: FLAG_KEEP},
    ld_temp:     1'b0,
    mar_ld:      MAR_KEEP,
    exx:         1'b0,
    ex_af:       1'b0
  };

endpackage

`default_nettype wire

// File: common/dp_types_pkg.sv
`default_nettype none

package dp_types_pkg;

  // ----------------------------------------
  // data widths
  // ----------------------------------------

  // the instruction set fixes both widths
  localparam int BYTE_W = 8;
  localparam int WORD_W = 16;

  // one byte on the internal or external data bus
  typedef logic [BYTE_W-1:0] byte_t;

  // one 16-bit address, or two registers read as a pair
  typedef logic [WORD_W-1:0] word_t;

  // ----------------------------------------
  // flag byte layout
  // ----------------------------------------

  // the flag register is kept as a plain byte so it can ride the data bus
  typedef logic [BYTE_W-1:0] flags_t;

  // bit positions inside flags_t
  localparam int FLAG_S  = 7;
  localparam int FLAG_Z  = 6;
  localparam int FLAG_H  = 4;
  localparam int FLAG_PV = 2;
  localparam int FLAG_N  = 1;
  localparam int FLAG_C  = 0;

  // bits 5 and 3 are not implemented and always read back as 0
  localparam flags_t FLAG_MASK = flags_t'((1 << FLAG_S) | (1 << FLAG_Z) |
                                          (1 << FLAG_H) | (1 << FLAG_PV) |
                                          (1 << FLAG_N) | (1 << FLAG_C));

endpackage

`default_nettype wire

// File: regfile/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                   clk,
  input  logic                   rst_n,
  input  dp_ctrl_pkg::micro_op_t uop,
  input  dp_types_pkg::byte_t    data_bus,
  input  dp_types_pkg::word_t    mar_value,
  output dp_types_pkg::byte_t    reg_byte,
  output dp_types_pkg::word_t    reg_pair
);

  import dp_types_pkg::*;
  import dp_ctrl_pkg::*;

  // ----------------------------------------
  // storage
  // ----------------------------------------

  // one flat array follows the reg8_t order, B to L sit in the first six
  // entries and IX, IY, SP and PC fill the rest as high/low byte pairs
  localparam int NUM_REGS = 14;

  // only B, C, D, E, H and L have a shadow bank for exx
  localparam int NUM_MAIN = 6;

  byte_t regs_q   [NUM_REGS];
  byte_t regs_d   [NUM_REGS];
  byte_t shadow_q [NUM_MAIN];
  byte_t shadow_d [NUM_MAIN];

  // ----------------------------------------
  // index decode
  // ----------------------------------------

  logic [3:0] byte_idx;
  logic [3:0] pair_hi_idx;
  logic [3:0] pair_lo_idx;
  logic       byte_valid;
  logic       pair_valid;

  assign byte_idx    = uop.reg_sel;

  // pair n maps to entries 2n and 2n+1
  assign pair_hi_idx = {uop.pair_sel, 1'b0};
  assign pair_lo_idx = {uop.pair_sel, 1'b1};

  // the enum codes above PCL and PC are unused and must not index the array
  assign byte_valid  = (uop.reg_sel <= REG_PCL);
  assign pair_valid  = (uop.pair_sel <= PAIR_PC);

  // ----------------------------------------
  // read ports
  // ----------------------------------------

  // both reads are combinational so the bus sees the current contents
  always_comb begin
    if (byte_valid) begin
      reg_byte = regs_q[byte_idx];
    end else begin
      reg_byte = '0;
    end
  end

  always_comb begin
    if (pair_valid) begin
      reg_pair = {regs_q[pair_hi_idx], regs_q[pair_lo_idx]};
    end else begin
      reg_pair = '0;
    end
  end

  // ----------------------------------------
  // next state
  // ----------------------------------------

  // later assignments win, which gives the required precedence
  // byte load first, then pair load, then exx on top of both
  always_comb begin
    regs_d   = regs_q;
    shadow_d = shadow_q;

    if (uop.reg_ld_byte && byte_valid) begin
      regs_d[byte_idx] = data_bus;
    end

    // a pair load comes from the MAR, never from the data bus
    if (uop.reg_ld_pair && pair_valid) begin
      regs_d[pair_hi_idx] = mar_value[15:8];
      regs_d[pair_lo_idx] = mar_value[7:0];
    end

    // exx swaps BC, DE and HL with their shadows in one cycle
    // loads aimed at IX, IY, SP or PC in the same cycle still land
    if (uop.exx) begin
      for (int i = 0; i < NUM_MAIN; i++) begin
        regs_d[i]   = shadow_q[i];
        shadow_d[i] = regs_q[i];
      end
    end
  end

  // ----------------------------------------
  // registers
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      regs_q   <= '{default: '0};
      shadow_q <= '{default: '0};
    end else begin
      regs_q   <= regs_d;
      shadow_q <= shadow_d;
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# builds the datapath testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_dp_top \
  --Mdir "$BUILD_DIR" -o sim_tb_dp_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb_dp_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the run passes only if the testbench printed the pass line
if grep -qx "STATUS: PASS" "$LOG"; then
  exit 0
fi
exit 1

// File: source/accum_flags.sv
`timescale 1ns/1ps
`default_nettype none

module accum_flags (
  input  logic                   clk,
  input  logic                   rst_n,
  input  dp_ctrl_pkg::micro_op_t uop,
  input  dp_types_pkg::byte_t    data_bus,
  input  dp_types_pkg::byte_t    alu_result,
  input  dp_types_pkg::flags_t   alu_flags,
  output dp_types_pkg::byte_t    a_value,
  output dp_types_pkg::flags_t   flags
);

  import dp_types_pkg::*;
  import dp_ctrl_pkg::*;

  // working pair and the shadow pair used by ex_af
  byte_t  a_q;
  byte_t  a_sh_q;
  flags_t f_q;
  flags_t f_sh_q;

  byte_t  a_next;
  flags_t f_base;
  flags_t f_next;
  logic   force_any;
  logic   f_we;

  // one forced action applied to one flag bit
  function automatic logic force_bit(input logic cur, input flag_act_t act);
    case (act)
      FLAG_SET: return 1'b1;
      FLAG_CLR: return 1'b0;
      default:  return cur;
    endcase
  endfunction

  // ----------------------------------------
  // next values
  // ----------------------------------------

  assign a_next = uop.a_from_alu ? alu_result : data_bus;

  // forces sit on top of whatever the ALU produced this cycle
  assign f_base = uop.f_from_alu ? alu_flags : f_q;

  always_comb begin
    f_next         = f_base;
    f_next[FLAG_S]  = force_bit(f_base[FLAG_S], uop.flag_force.s);
    f_next[FLAG_Z]  = force_bit(f_base[FLAG_Z], uop.flag_force.z);
    f_next[FLAG_H]  = force_bit(f_base[FLAG_H], uop.flag_force.h);
    f_next[FLAG_PV] = force_bit(f_base[FLAG_PV], uop.flag_force.pv);
    f_next[FLAG_N]  = force_bit(f_base[FLAG_N], uop.flag_force.n);
    f_next[FLAG_C]  = force_bit(f_base[FLAG_C], uop.flag_force.c);
    // the two unimplemented bits are held at zero
    f_next         = f_next & FLAG_MASK;
  end

  // a force alone is enough to write F
  assign force_any = (uop.flag_force.s != FLAG_KEEP) || (uop.flag_force.z != FLAG_KEEP) ||
                     (uop.flag_force.h != FLAG_KEEP) || (uop.flag_force.pv != FLAG_KEEP) ||
                     (uop.flag_force.n != FLAG_KEEP) || (uop.flag_force.c != FLAG_KEEP);
  assign f_we      = uop.f_from_alu || force_any;

  // ----------------------------------------
  // registers
  // ----------------------------------------

  // ex_af wins over ld_a and every flag update in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      a_q    <= '0;
      a_sh_q <= '0;
      f_q    <= '0;
      f_sh_q <= '0;
    end else if (uop.ex_af) begin
      a_q    <= a_sh_q;
      a_sh_q <= a_q;
      f_q    <= f_sh_q;
      f_sh_q <= f_q;
    end else begin
      if (uop.ld_a) begin
        a_q <= a_next;
      end
      if (f_we) begin
        f_q <= f_next;
      end
    end
  end

  assign a_value = a_q;
  assign flags   = f_q;

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  dp_types_pkg::byte_t  a_value,
  input  dp_types_pkg::byte_t  operand,
  input  dp_ctrl_pkg::alu_op_t alu_op,
  input  dp_types_pkg::flags_t flags_in,
  output dp_types_pkg::byte_t  result,
  output dp_types_pkg::flags_t flags_out
);

  import dp_types_pkg::*;
  import dp_ctrl_pkg::*;

  // ----------------------------------------
  // adders
  // ----------------------------------------

  // one extra bit catches the carry or borrow out of bit 7
  logic [8:0] add_full;
  logic [8:0] sub_full;

  // the nibble sums give the carry or borrow from bit 3 into bit 4
  logic [4:0] add_half;
  logic [4:0] sub_half;

  // subtraction is A minus the operand, borrow shows up as bit 8 set
  assign add_full = {1'b0, a_value} + {1'b0, operand};
  assign sub_full = {1'b0, a_value} - {1'b0, operand};
  assign add_half = {1'b0, a_value[3:0]} + {1'b0, operand[3:0]};
  assign sub_half = {1'b0, a_value[3:0]} - {1'b0, operand[3:0]};

  // ----------------------------------------
  // result and flags
  // ----------------------------------------

  always_comb begin
    result    = operand;
    flags_out = flags_in;

    case (alu_op)
      // INC and DEC work on A alone and never touch C
      ALU_INC: begin
        result            = a_value + 8'd1;
        flags_out[FLAG_H]  = (a_value[3:0] == 4'hF);
        flags_out[FLAG_PV] = (a_value == 8'h7F);
        flags_out[FLAG_N]  = 1'b0;
      end
      ALU_DEC: begin
        result            = a_value - 8'd1;
        flags_out[FLAG_H]  = (a_value[3:0] == 4'h0);
        flags_out[FLAG_PV] = (a_value == 8'h80);
        flags_out[FLAG_N]  = 1'b1;
      end
      // overflow when both inputs share a sign and the result flips it
      ALU_ADD: begin
        result            = add_full[7:0];
        flags_out[FLAG_C]  = add_full[8];
        flags_out[FLAG_H]  = add_half[4];
        flags_out[FLAG_PV] = (a_value[7] == operand[7]) && (add_full[7] != a_value[7]);
        flags_out[FLAG_N]  = 1'b0;
      end
      // overflow when the signs differ and the result leaves the sign of A
      ALU_SUB: begin
        result            = sub_full[7:0];
        flags_out[FLAG_C]  = sub_full[8];
        flags_out[FLAG_H]  = sub_half[4];
        flags_out[FLAG_PV] = (a_value[7] != operand[7]) && (sub_full[7] != a_value[7]);
        flags_out[FLAG_N]  = 1'b1;
      end
      // pass hands the operand through with the flags as they were
      default: begin
        result    = operand;
        flags_out = flags_in;
      end
    endcase

    // sign and zero follow the result for every arithmetic op
    if (alu_op != ALU_PASS) begin
      flags_out[FLAG_S] = result[7];
      flags_out[FLAG_Z] = (result == '0);
    end
  end

endmodule

`default_nettype wire

// File: source/dp_top.sv
`timescale 1ns/1ps
`default_nettype none

module dp_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  dp_ctrl_pkg::micro_op_t uop,
  input  dp_types_pkg::byte_t    data_in,
  output dp_types_pkg::byte_t    data_out,
  output logic                   data_oe,
  output dp_types_pkg::word_t    addr_out,
  output logic                   addr_oe,
  output dp_types_pkg::flags_t   flags
);

  import dp_types_pkg::*;

  // ----------------------------------------
  // shared nets
  // ----------------------------------------

  // the one internal data bus, steered by internal_bus
  byte_t  data_bus;

  byte_t  reg_byte;
  word_t  reg_pair;
  word_t  mar_value;
  byte_t  a_value;
  byte_t  alu_result;
  flags_t alu_flags;

  // the external data output simply mirrors the internal bus
  assign data_out = data_bus;

  // ----------------------------------------
  // peers
  // ----------------------------------------

  register_file i_register_file (
    .clk       (clk),
    .rst_n     (rst_n),
    .uop       (uop),
    .data_bus  (data_bus),
    .mar_value (mar_value),
    .reg_byte  (reg_byte),
    .reg_pair  (reg_pair)
  );

  // the second operand is always the data bus, TEMP reaches it via DS_TEMP
  alu i_alu (
    .a_value   (a_value),
    .operand   (data_bus),
    .alu_op    (uop.alu_op),
    .flags_in  (flags),
    .result    (alu_result),
    .flags_out (alu_flags)
  );

  accum_flags i_accum_flags (
    .clk        (clk),
    .rst_n      (rst_n),
    .uop        (uop),
    .data_bus   (data_bus),
    .alu_result (alu_result),
    .alu_flags  (alu_flags),
    .a_value    (a_value),
    .flags      (flags)
  );

  internal_bus i_internal_bus (
    .clk       (clk),
    .rst_n     (rst_n),
    .uop       (uop),
    .data_in   (data_in),
    .reg_byte  (reg_byte),
    .a_value   (a_value),
    .flags     (flags),
    .reg_pair  (reg_pair),
    .data_bus  (data_bus),
    .mar_value (mar_value),
    .addr_out  (addr_out),
    .data_oe   (data_oe),
    .addr_oe   (addr_oe)
  );

endmodule

`default_nettype wire

// File: source/internal_bus.sv
`timescale 1ns/1ps
`default_nettype none

module internal_bus (
  input  logic                   clk,
  input  logic                   rst_n,
  input  dp_ctrl_pkg::micro_op_t uop,
  input  dp_types_pkg::byte_t    data_in,
  input  dp_types_pkg::byte_t    reg_byte,
  input  dp_types_pkg::byte_t    a_value,
  input  dp_types_pkg::flags_t   flags,
  input  dp_types_pkg::word_t    reg_pair,
  output dp_types_pkg::byte_t    data_bus,
  output dp_types_pkg::word_t    mar_value,
  output dp_types_pkg::word_t    addr_out,
  output logic                   data_oe,
  output logic                   addr_oe
);

  import dp_types_pkg::*;
  import dp_ctrl_pkg::*;

  // TEMP holds a byte for a later ALU op, MAR holds an outgoing address
  byte_t temp_q;
  word_t mar_q;

  // ----------------------------------------
  // bus steering
  // ----------------------------------------

  // exactly one source is muxed onto the data bus, the external
  // input is the default when no internal block drives it
  always_comb begin
    case (uop.data_src)
      DS_EXT:  data_bus = data_in;
      DS_REG:  data_bus = reg_byte;
      DS_A:    data_bus = a_value;
      DS_F:    data_bus = flags;
      DS_TEMP: data_bus = temp_q;
      default: data_bus = '0;
    endcase
  end

  always_comb begin
    case (uop.addr_src)
      AS_MAR:  addr_out = mar_q;
      AS_PAIR: addr_out = reg_pair;
      default: addr_out = '0;
    endcase
  end

  // any internal driver on the data bus means the chip drives it outward
  assign data_oe = (uop.data_src != DS_EXT);
  assign addr_oe = (uop.addr_src != AS_NONE);

  // ----------------------------------------
  // TEMP and MAR
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      temp_q <= '0;
      mar_q  <= '0;
    end else begin
      if (uop.ld_temp) begin
        temp_q <= data_bus;
      end
      // byte loads fill one half and keep the other
      case (uop.mar_ld)
        MAR_HI:   mar_q[15:8] <= data_bus;
        MAR_LO:   mar_q[7:0]  <= data_bus;
        MAR_PAIR: mar_q       <= reg_pair;
        default:  mar_q       <= mar_q;
      endcase
    end
  end

  assign mar_value = mar_q;

endmodule

`default_nettype wire

// File: tb.f
+incdir+verification
common/dp_types_pkg.sv
common/dp_ctrl_pkg.sv
regfile/register_file.sv
source/alu.sv
source/accum_flags.sv
source/internal_bus.sv
source/dp_top.sv
verification/tb_dp_top.sv

// File: verification/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// ----------------------------------------
// drive and compare
// ----------------------------------------

// inputs change on the falling edge, outputs are read 2 ns later
// while the clock is still low and nothing else moves
task automatic step(input micro_op_t u, input byte_t d);
  @(negedge clk);
  uop     = u;
  data_in = d;
  #2;
endtask

task automatic check_byte(input string what, input byte_t got, input byte_t want);
  assert (got == want) else begin
    error_count++;
    $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, want);
  end
endtask

task automatic check_word(input string what, input word_t got, input word_t want);
  assert (got == want) else begin
    error_count++;
    $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, want);
  end
endtask

task automatic check_bit(input string what, input logic got, input logic want);
  assert (got == want) else begin
    error_count++;
    $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, want);
  end
endtask

// ----------------------------------------
// micro-operations
// ----------------------------------------

// byte load from the external input into register r
task automatic load_reg(input int r, input byte_t v);
  micro_op_t u;
  u             = MICRO_OP_IDLE;
  u.reg_sel     = reg8_t'(r);
  u.reg_ld_byte = 1'b1;
  step(u, v);
  exp_regs[r] = v;
endtask

// A takes the bus value, the ALU is left on PASS and F stays as it was
task automatic load_a(input byte_t v);
  micro_op_t u;
  u      = MICRO_OP_IDLE;
  u.ld_a = 1'b1;
  step(u, v);
  exp_a = v;
endtask

// MAR is built from two byte loads, high byte first
task automatic load_mar(input word_t w);
  micro_op_t u;
  u        = MICRO_OP_IDLE;
  u.mar_ld = MAR_HI;
  step(u, w[15:8]);
  u.mar_ld = MAR_LO;
  step(u, w[7:0]);
  exp_mar = w;
endtask

// put one byte register on the data bus and compare it with the model
task automatic expect_reg(input int r);
  micro_op_t u;
  u          = MICRO_OP_IDLE;
  u.data_src = DS_REG;
  u.reg_sel  = reg8_t'(r);
  step(u, 8'h00);
  check_byte($sformatf("register %0d on data_out", r), data_out, exp_regs[r]);
endtask

task automatic expect_a();
  micro_op_t u;
  u          = MICRO_OP_IDLE;
  u.data_src = DS_A;
  step(u, 8'h00);
  check_byte("A on data_out", data_out, exp_a);
endtask

// F is checked both on the data bus and on the flags port
task automatic expect_f();
  micro_op_t u;
  u          = MICRO_OP_IDLE;
  u.data_src = DS_F;
  step(u, 8'h00);
  check_byte("F on data_out", data_out, exp_f);
  check_byte("flags port", flags, exp_f);
endtask

// ----------------------------------------
// reference flag model
// ----------------------------------------

// index k follows the order of flag_force_t, S first and C last
function automatic int flag_pos(input int k);
  case (k)
    0:       return FLAG_S;
    1:       return FLAG_Z;
    2:       return FLAG_H;
    3:       return FLAG_PV;
    4:       return FLAG_N;
    default: return FLAG_C;
  endcase
endfunction

function automatic flag_force_t force_one(input int k, input flag_act_t act);
  flag_force_t ff;
  ff = '{default: FLAG_KEEP};
  case (k)
    0:       ff.s = act;
    1:       ff.z = act;
    2:       ff.h = act;
    3:       ff.pv = act;
    4:       ff.n = act;
    default: ff.c = act;
  endcase
  return ff;
endfunction

// a force on every flag writes a whole chosen flag byte
function automatic flag_force_t force_all(input flags_t f);
  flag_force_t ff;
  ff.s  = f[FLAG_S] ? FLAG_SET : FLAG_CLR;
  ff.z  = f[FLAG_Z] ? FLAG_SET : FLAG_CLR;
  ff.h  = f[FLAG_H] ? FLAG_SET : FLAG_CLR;
  ff.pv = f[FLAG_PV] ? FLAG_SET : FLAG_CLR;
  ff.n  = f[FLAG_N] ? FLAG_SET : FLAG_CLR;
  ff.c  = f[FLAG_C] ? FLAG_SET : FLAG_CLR;
  return ff;
endfunction

// expected result and flags, worked out with plain integer arithmetic
// signed overflow is a sum outside -128..127, borrow is a smaller minuend
function automatic void ref_alu(input alu_op_t op, input byte_t a, input byte_t b,
                                input flags_t f_in, output byte_t res,
                                output flags_t f_out);
  int ua;
  int ub;
  int sa;
  int sb;
  ua    = int'(a);
  ub    = int'(b);
  sa    = int'($signed(a));
  sb    = int'($signed(b));
  res   = b;
  f_out = f_in;
  case (op)
    ALU_INC: begin
      res            = byte_t'(ua + 1);
      f_out[FLAG_H]  = (ua % 16 == 15);
      f_out[FLAG_PV] = (sa + 1 > 127);
      f_out[FLAG_N]  = 1'b0;
    end
    ALU_DEC: begin
      res            = byte_t'(ua - 1);
      f_out[FLAG_H]  = (ua % 16 == 0);
      f_out[FLAG_PV] = (sa - 1 < -128);
      f_out[FLAG_N]  = 1'b1;
    end
    ALU_ADD: begin
      res            = byte_t'(ua + ub);
      f_out[FLAG_C]  = (ua + ub > 255);
      f_out[FLAG_H]  = (ua % 16 + ub % 16 > 15);
      f_out[FLAG_PV] = (sa + sb > 127) || (sa + sb < -128);
      f_out[FLAG_N]  = 1'b0;
    end
    ALU_SUB: begin
      res            = byte_t'(ua - ub);
      f_out[FLAG_C]  = (ua < ub);
      f_out[FLAG_H]  = (ua % 16 < ub % 16);
      f_out[FLAG_PV] = (sa - sb > 127) || (sa - sb < -128);
      f_out[FLAG_N]  = 1'b1;
    end
    default: ;
  endcase
  if (op != ALU_PASS) begin
    f_out[FLAG_S] = res[7];
    f_out[FLAG_Z] = (res == 8'h00);
  end
endfunction

`endif

// File: verification/tb_dp_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dp_top;

  import dp_types_pkg::*;
  import dp_ctrl_pkg::*;

  // ----------------------------------------
  // run constants
  // ----------------------------------------

  localparam int          CLK_PERIOD   = 20;
  localparam int          RESET_CYCLES = 5;
  localparam int          ALU_ITERS    = 8;
  localparam int          NUM_REGS     = 14;
  localparam logic [31:0] SEED         = 32'h6d29e742;

  // implemented flag bits S, Z, H, PV, N and C
  localparam flags_t FLAG_BITS = 8'b1101_0111;

  // worst case cycles of each test, the watchdog allows twice their sum
  localparam int RESET_TEST_CYC = 20;
  localparam int LOAD_TEST_CYC  = 80;
  localparam int ALU_TEST_CYC   = ALU_ITERS * 5 * 2 * 6;
  localparam int FORCE_TEST_CYC = 100;
  localparam int EXCH_TEST_CYC  = 80;
  localparam int TOTAL_CYC      = RESET_CYCLES + RESET_TEST_CYC + LOAD_TEST_CYC +
                                  ALU_TEST_CYC + FORCE_TEST_CYC + EXCH_TEST_CYC;
  localparam int WATCHDOG_NS    = 2 * TOTAL_CYC * CLK_PERIOD;

  logic      clk;
  logic      rst_n;
  micro_op_t uop;
  byte_t     data_in;
  byte_t     data_out;
  logic      data_oe;
  word_t     addr_out;
  logic      addr_oe;
  flags_t    flags;

  int error_count;
  int test_count;
  int fail_count;

  // expected contents of every register, kept in reg8_t order
  byte_t  exp_regs   [NUM_REGS];
  byte_t  exp_shadow [6];
  byte_t  exp_a;
  byte_t  exp_a_sh;
  flags_t exp_f;
  flags_t exp_f_sh;
  word_t  exp_mar;

  `include "tb_tasks.svh"

  dp_top i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .uop      (uop),
    .data_in  (data_in),
    .data_out (data_out),
    .data_oe  (data_oe),
    .addr_out (addr_out),
    .addr_oe  (addr_oe),
    .flags    (flags)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // both enables follow their selects in every cycle out of reset
  enables_follow_selects: assert property (@(posedge clk) disable iff (!rst_n)
      (data_oe == (uop.data_src != DS_EXT)) && (addr_oe == (uop.addr_src != AS_NONE)))
    else begin
      error_count++;
      $display("[ERROR] %0t: output enables do not match the bus selects", $time);
    end

  // ----------------------------------------
  // model helpers
  // ----------------------------------------

  task automatic swap_main();
    byte_t t;
    for (int i = 0; i < 6; i++) begin
      t             = exp_regs[i];
      exp_regs[i]   = exp_shadow[i];
      exp_shadow[i] = t;
    end
  endtask

  task automatic swap_af();
    byte_t  ta;
    flags_t tf;
    ta       = exp_a;
    tf       = exp_f;
    exp_a    = exp_a_sh;
    exp_f    = exp_f_sh;
    exp_a_sh = ta;
    exp_f_sh = tf;
  endtask

  task automatic expect_all_regs();
    for (int r = 0; r < NUM_REGS; r++) begin
      expect_reg(r);
    end
  endtask

  task automatic end_test(input string name, input int start_errors);
    test_count++;
    if (error_count == start_errors) begin
      $display("test %0d, %s: ok", test_count, name);
    end else begin
      fail_count++;
      $display("test %0d, %s: failed with %0d errors", test_count, name,
               error_count - start_errors);
    end
  endtask

  // ----------------------------------------
  // tests
  // ----------------------------------------

  task automatic test_reset_state();
    step(MICRO_OP_IDLE, byte_t'($urandom()));
    check_bit("data_oe when idle", data_oe, 1'b0);
    check_bit("addr_oe when idle", addr_oe, 1'b0);
    check_byte("flags after reset", flags, 8'h00);
    expect_all_regs();
  endtask

  task automatic test_reg_load();
    micro_op_t u;
    for (int r = 0; r < NUM_REGS; r++) begin
      load_reg(r, byte_t'($urandom()));
      expect_reg(r);
    end
    load_mar(word_t'($urandom()));
    u          = MICRO_OP_IDLE;
    u.addr_src = AS_MAR;
    step(u, 8'h00);
    check_word("MAR on addr_out", addr_out, exp_mar);
    // every pair is loaded from a fresh MAR and read back as an address
    for (int p = 0; p < 7; p++) begin
      load_mar(word_t'($urandom()));
      u             = MICRO_OP_IDLE;
      u.pair_sel    = reg16_t'(p);
      u.reg_ld_pair = 1'b1;
      step(u, 8'h00);
      exp_regs[2*p]   = exp_mar[15:8];
      exp_regs[2*p+1] = exp_mar[7:0];
      u          = MICRO_OP_IDLE;
      u.pair_sel = reg16_t'(p);
      u.addr_src = AS_PAIR;
      step(u, 8'h00);
      check_word($sformatf("pair %0d on addr_out", p), addr_out,
                 {exp_regs[2*p], exp_regs[2*p+1]});
    end
    // HL goes back into the MAR in one cycle
    load_mar(word_t'($urandom()));
    u          = MICRO_OP_IDLE;
    u.pair_sel = PAIR_HL;
    u.mar_ld   = MAR_PAIR;
    step(u, 8'h00);
    exp_mar    = {exp_regs[4], exp_regs[5]};
    u          = MICRO_OP_IDLE;
    u.addr_src = AS_MAR;
    step(u, 8'h00);
    check_word("MAR after pair copy", addr_out, exp_mar);
  endtask

  task automatic test_alu();
    micro_op_t u;
    alu_op_t   op;
    byte_t     a;
    byte_t     b;
    byte_t     res;
    flags_t    f_new;
    for (int i = 0; i < ALU_ITERS; i++) begin
      for (int k = 0; k < 5; k++) begin
        for (int src = 0; src < 2; src++) begin
          op = alu_op_t'(k);
          a  = byte_t'($urandom());
          b  = byte_t'($urandom());
          // the first pass sits on the signed boundary for INC and DEC
          if (i == 0) begin
            a = (op == ALU_DEC) ? 8'h80 : 8'h7F;
          end
          load_a(a);
          if (src == 1) begin
            u         = MICRO_OP_IDLE;
            u.ld_temp = 1'b1;
            step(u, b);
          end
          ref_alu(op, exp_a, b, exp_f, res, f_new);
          u            = MICRO_OP_IDLE;
          u.data_src   = (src == 1) ? DS_TEMP : DS_EXT;
          u.alu_op     = op;
          u.ld_a       = 1'b1;
          u.a_from_alu = 1'b1;
          u.f_from_alu = 1'b1;
          // with TEMP on the bus the external byte must not matter
          step(u, (src == 1) ? ~b : b);
          exp_a = res;
          exp_f = f_new;
          expect_a();
          expect_f();
        end
      end
    end
  endtask

  task automatic test_flag_force();
    micro_op_t u;
    flag_act_t act;
    flags_t    base;
    flags_t    alu_f;
    byte_t     alu_res;
    byte_t     b;
    for (int k = 0; k < 6; k++) begin
      for (int j = 0; j < 2; j++) begin
        act = (j == 0) ? FLAG_CLR : FLAG_SET;
        // a random start so the neighbouring bits hold both values
        base         = flags_t'($urandom()) & FLAG_BITS;
        u            = MICRO_OP_IDLE;
        u.flag_force = force_all(base);
        step(u, 8'h00);
        exp_f        = base;
        u.flag_force = force_one(k, act);
        step(u, 8'h00);
        exp_f[flag_pos(k)] = (act == FLAG_SET);
        expect_f();
        // the force lands on top of an ALU flag load in the same cycle
        b = byte_t'($urandom());
        ref_alu(ALU_ADD, exp_a, b, exp_f, alu_res, alu_f);
        u.alu_op     = ALU_ADD;
        u.f_from_alu = 1'b1;
        step(u, b);
        exp_f              = alu_f;
        exp_f[flag_pos(k)] = (act == FLAG_SET);
        expect_f();
      end
    end
  endtask

  task automatic test_exchange();
    micro_op_t u;
    // exx beats a byte load into B in the same cycle
    u             = MICRO_OP_IDLE;
    u.exx         = 1'b1;
    u.reg_sel     = REG_B;
    u.reg_ld_byte = 1'b1;
    step(u, byte_t'($urandom()));
    swap_main();
    expect_all_regs();
    for (int r = 0; r < 6; r++) begin
      load_reg(r, byte_t'($urandom()));
    end
    u     = MICRO_OP_IDLE;
    u.exx = 1'b1;
    step(u, 8'h00);
    swap_main();
    expect_all_regs();
    step(u, 8'h00);
    swap_main();
    expect_all_regs();
    // ex_af beats ld_a and an ALU flag load in the same cycle
    load_a(byte_t'($urandom()));
    u            = MICRO_OP_IDLE;
    u.ex_af      = 1'b1;
    u.ld_a       = 1'b1;
    u.f_from_alu = 1'b1;
    u.alu_op     = ALU_ADD;
    step(u, byte_t'($urandom()));
    swap_af();
    expect_a();
    expect_f();
    load_a(byte_t'($urandom()));
    u       = MICRO_OP_IDLE;
    u.ex_af = 1'b1;
    step(u, 8'h00);
    swap_af();
    expect_a();
    expect_f();
    step(u, 8'h00);
    swap_af();
    expect_a();
    expect_f();
  endtask

  // ----------------------------------------
  // sequence and watchdog
  // ----------------------------------------

  initial begin
    int start_errors;
    void'($urandom(SEED));
    clk         = 1'b0;
    rst_n       = 1'b0;
    uop         = MICRO_OP_IDLE;
    data_in     = 8'h00;
    error_count = 0;
    test_count  = 0;
    fail_count  = 0;
    exp_regs    = '{default: 8'h00};
    exp_shadow  = '{default: 8'h00};
    exp_a       = 8'h00;
    exp_a_sh    = 8'h00;
    exp_f       = 8'h00;
    exp_f_sh    = 8'h00;
    exp_mar     = 16'h0000;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    start_errors = error_count;
    test_reset_state();
    end_test("state after reset", start_errors);
    start_errors = error_count;
    test_reg_load();
    end_test("register and MAR loads", start_errors);
    start_errors = error_count;
    test_alu();
    end_test("ALU results and flags", start_errors);
    start_errors = error_count;
    test_flag_force();
    end_test("forced flags", start_errors);
    start_errors = error_count;
    test_exchange();
    end_test("register exchanges", start_errors);

    $display("tests run %0d, tests failed %0d, failed checks %0d",
             test_count, fail_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
